// File: project.f
source/sdram_pkg.sv
source/sdram_refresh_timer.sv
source/sdram_cmd_fsm.sv
source/sdram_datapath.sv
source/sdram_controller.sv
verif/sdram_model.sv
verif/sdram_checker.sv
verif/sdram_sva.sv
verif/tb_sdram_controller.sv

// File: run_sim.sh
#!/bin/sh
# Build with Verilator, run, and decide the result from the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f project.f --top-module tb_sdram_controller \
  -o sim_tb \
  && ./obj_dir/sim_tb > sim.log 2>&1 \
  || echo "Test failed" >> sim.log
cat sim.log
grep -q "Test failed" sim.log && exit 1
grep -q "Test completed successfully" sim.log || exit 1
exit 0

// File: source/sdram_cmd_fsm.sv
/* Power-up schedule and command FSM. Waits are cycle counts from the top
   level, and each must be at least one. The request is held until ack. */
`timescale 1ns/10ps
`default_nettype none

module sdram_cmd_fsm
  import sdram_pkg::*;
#(
  parameter int unsigned INIT_WAIT_CYCLES      = 33200,
  parameter int unsigned PRECHARGE_WAIT_CYCLES = 3,
  parameter int unsigned REFRESH_WAIT_CYCLES   = 10,
  parameter int unsigned MODE_WAIT_CYCLES      = 3,
  parameter int unsigned ACTIVE_WAIT_CYCLES    = 3,
  parameter int unsigned WRITE_WAIT_CYCLES     = 6
) (
  input  wire          fpga_clk,
  input  wire          fpga_reset,
  input  wire          fpga_req,
  input  wire          wr_en,
  input  wire          rd_en,
  input  wire          refresh_due,
  output sdram_state_e state,
  output sdram_cmd_e   cmd,
  output logic         start,
  output logic         refresh_start,
  output logic         fpga_ack,
  output logic         clk_en,
  output logic         write_window
);

  // Read holds until the word has come back from the SDRAM
  localparam int unsigned READ_WAIT_CYCLES = CAS_LATENCY + 1;

  // Power-up schedule offsets, measured from the first init cycle
  localparam int unsigned PRE_AT   = INIT_WAIT_CYCLES;
  localparam int unsigned REF1_AT  = PRE_AT + PRECHARGE_WAIT_CYCLES;
  localparam int unsigned REF2_AT  = REF1_AT + REFRESH_WAIT_CYCLES;
  localparam int unsigned MODE_AT  = REF2_AT + REFRESH_WAIT_CYCLES;
  localparam int unsigned CNT_SPAN = MODE_AT + MODE_WAIT_CYCLES + ACTIVE_WAIT_CYCLES +
                                     WRITE_WAIT_CYCLES + READ_WAIT_CYCLES;
  localparam int unsigned CNT_W    = $clog2(CNT_SPAN + 1);

  localparam logic [CNT_W-1:0] PRE_CNT       = CNT_W'(PRE_AT);
  localparam logic [CNT_W-1:0] REF1_CNT      = CNT_W'(REF1_AT);
  localparam logic [CNT_W-1:0] REF2_CNT      = CNT_W'(REF2_AT);
  localparam logic [CNT_W-1:0] MODE_CNT      = CNT_W'(MODE_AT);
  localparam logic [CNT_W-1:0] MODE_LAST     = CNT_W'(MODE_WAIT_CYCLES - 1);
  localparam logic [CNT_W-1:0] ACTIVE_LAST   = CNT_W'(ACTIVE_WAIT_CYCLES - 1);
  localparam logic [CNT_W-1:0] REFRESH_LAST  = CNT_W'(REFRESH_WAIT_CYCLES - 1);
  localparam logic [CNT_W-1:0] READ_LAST     = CNT_W'(READ_WAIT_CYCLES - 1);
  localparam logic [CNT_W-1:0] WRITE_LAST    = CNT_W'(WRITE_WAIT_CYCLES - 1);

  sdram_state_e     next_state;
  sdram_cmd_e       next_cmd;
  logic [CNT_W-1:0] wait_cnt;
  logic             op_done;

  // Last cycle of a read, write or refresh, where a new request may enter
  assign op_done = ((state == ST_READ)    && (wait_cnt == READ_LAST))  ||
                   ((state == ST_WRITE)   && (wait_cnt == WRITE_LAST)) ||
                   ((state == ST_REFRESH) && (wait_cnt == REFRESH_LAST));

  always_comb begin
    next_state = state;
    next_cmd   = CMD_NOP;
    start      = 1'b0;
    case (state)
      ST_INIT: begin
        // Fixed schedule off the free-running wait counter
        if (wait_cnt == '0) begin
          next_cmd = CMD_DESELECT;
        end else if (wait_cnt == PRE_CNT) begin
          next_cmd = CMD_PRECHARGE;
        end else if (wait_cnt == REF1_CNT || wait_cnt == REF2_CNT) begin
          next_cmd = CMD_REFRESH;
        end else if (wait_cnt == MODE_CNT) begin
          next_state = ST_MODE;
          next_cmd   = CMD_LOAD_MODE;
        end
      end
      ST_MODE: begin
        if (wait_cnt == MODE_LAST) begin
          next_state = ST_IDLE;
        end
      end
      ST_ACTIVATE: begin
        // Row open, issue the access with auto precharge
        if (wait_cnt == ACTIVE_LAST) begin
          if (wr_en) begin
            next_state = ST_WRITE;
            next_cmd   = CMD_WRITE;
          end else if (rd_en) begin
            next_state = ST_READ;
            next_cmd   = CMD_READ;
          end else begin
            next_state = ST_IDLE;
          end
        end
      end
      ST_IDLE, ST_READ, ST_WRITE, ST_REFRESH: begin
        // Refresh wins over a waiting request
        if (state == ST_IDLE || op_done) begin
          if (refresh_due) begin
            next_state = ST_REFRESH;
            next_cmd   = CMD_REFRESH;
          end else if (fpga_req) begin
            next_state = ST_ACTIVATE;
            next_cmd   = CMD_ACTIVE;
            start      = 1'b1;
          end else begin
            next_state = ST_IDLE;
          end
        end
      end
      default: begin
        next_state = ST_IDLE;
      end
    endcase
  end

  // State and command registered together so both change on the same edge
  always_ff @(posedge fpga_clk or posedge fpga_reset) begin
    if (fpga_reset) begin
      state <= ST_INIT;
      cmd   <= CMD_NOP;
    end else begin
      state <= next_state;
      cmd   <= next_cmd;
    end
  end

  // Counts cycles spent in the current state
  always_ff @(posedge fpga_clk or posedge fpga_reset) begin
    if (fpga_reset) begin
      wait_cnt <= '0;
    end else if (next_state != state) begin
      wait_cnt <= '0;
    end else begin
      wait_cnt <= wait_cnt + 1'b1;
    end
  end

  // Cycle before the write command, so the data lines enable with it
  assign write_window  = (state == ST_ACTIVATE) && (next_state == ST_WRITE);

  // Clears the refresh timer on the refresh command cycle
  assign refresh_start = (state == ST_REFRESH) && (wait_cnt == '0);

  // Ack on the read or write command cycle
  assign fpga_ack = ((state == ST_READ) || (state == ST_WRITE)) && (wait_cnt == '0);

  // Clock enable low only in the very first init cycle
  assign clk_en = !((state == ST_INIT) && (wait_cnt == '0));

endmodule

`default_nettype wire

// File: source/sdram_controller.sv
/* SDRAM controller top level. The tristate data pad and a low byte mask
   are expected on the board side. Default waits suit a 166 MHz clock. */
`timescale 1ns/10ps
`default_nettype none

module sdram_controller
  import sdram_pkg::*;
#(
  // Power-up wait, about 200 us
  parameter int unsigned INIT_WAIT_CYCLES        = 33200,
  // tRP
  parameter int unsigned PRECHARGE_WAIT_CYCLES   = 3,
  // tRC
  parameter int unsigned REFRESH_WAIT_CYCLES     = 10,
  // tMRD
  parameter int unsigned MODE_WAIT_CYCLES        = 3,
  // tRCD
  parameter int unsigned ACTIVE_WAIT_CYCLES      = 3,
  // tWR plus tRP plus the data cycle
  parameter int unsigned WRITE_WAIT_CYCLES       = 6,
  // Average refresh period less a margin for an access in flight
  parameter int unsigned REFRESH_INTERVAL_CYCLES = 1280
) (
  input  wire                   fpga_clk,
  input  wire                   fpga_reset,
  input  wire                   fpga_req,
  input  wire sdram_req_t       fpga_request,
  output logic                  fpga_ack,
  output logic [DATA_WIDTH-1:0] fpga_rd_data,
  output logic                  fpga_rd_valid,
  output sdram_pins_t           ram_pins,
  output logic [DATA_WIDTH-1:0] ram_dq_out,
  output logic                  ram_dq_oe,
  input  wire  [DATA_WIDTH-1:0] ram_dq_in
);

  sdram_state_e          state;
  sdram_cmd_e            cmd;
  logic                  start;
  logic                  refresh_start;
  logic                  refresh_due;
  logic                  clk_en;
  logic                  write_window;
  logic [ROW_WIDTH-1:0]  row_col;
  logic [BANK_WIDTH-1:0] bank;

  sdram_refresh_timer #(
    .REFRESH_INTERVAL_CYCLES(REFRESH_INTERVAL_CYCLES)
  ) refresh_timer_inst (
    .fpga_clk      (fpga_clk),
    .fpga_reset    (fpga_reset),
    .refresh_start (refresh_start),
    .refresh_due   (refresh_due)
  );

  sdram_cmd_fsm #(
    .INIT_WAIT_CYCLES      (INIT_WAIT_CYCLES),
    .PRECHARGE_WAIT_CYCLES (PRECHARGE_WAIT_CYCLES),
    .REFRESH_WAIT_CYCLES   (REFRESH_WAIT_CYCLES),
    .MODE_WAIT_CYCLES      (MODE_WAIT_CYCLES),
    .ACTIVE_WAIT_CYCLES    (ACTIVE_WAIT_CYCLES),
    .WRITE_WAIT_CYCLES     (WRITE_WAIT_CYCLES)
  ) cmd_fsm_inst (
    .fpga_clk      (fpga_clk),
    .fpga_reset    (fpga_reset),
    .fpga_req      (fpga_req),
    .wr_en         (fpga_request.wr_en),
    .rd_en         (fpga_request.rd_en),
    .refresh_due   (refresh_due),
    .state         (state),
    .cmd           (cmd),
    .start         (start),
    .refresh_start (refresh_start),
    .fpga_ack      (fpga_ack),
    .clk_en        (clk_en),
    .write_window  (write_window)
  );

  sdram_datapath datapath_inst (
    .fpga_clk      (fpga_clk),
    .fpga_reset    (fpga_reset),
    .state         (state),
    .start         (start),
    .write_window  (write_window),
    .fpga_request  (fpga_request),
    .row_col       (row_col),
    .bank          (bank),
    .ram_dq_out    (ram_dq_out),
    .ram_dq_oe     (ram_dq_oe),
    .ram_dq_in     (ram_dq_in),
    .fpga_rd_data  (fpga_rd_data),
    .fpga_rd_valid (fpga_rd_valid)
  );

  // Command side pins gathered for the board
  assign ram_pins = '{cmd: cmd, addr: row_col, bank: bank, clk_en: clk_en};

endmodule

`default_nettype wire

// File: source/sdram_datapath.sv
/* Request capture, address and bank mux, and data path. Write data is
   driven with the write command, read data is taken CAS_LATENCY cycles later. */
`timescale 1ns/10ps
`default_nettype none

module sdram_datapath
  import sdram_pkg::*;
(
  input  wire                   fpga_clk,
  input  wire                   fpga_reset,
  input  wire sdram_state_e     state,
  input  wire                   start,
  input  wire                   write_window,
  input  wire sdram_req_t       fpga_request,
  output logic [ROW_WIDTH-1:0]  row_col,
  output logic [BANK_WIDTH-1:0] bank,
  output logic [DATA_WIDTH-1:0] ram_dq_out,
  output logic                  ram_dq_oe,
  input  wire  [DATA_WIDTH-1:0] ram_dq_in,
  output logic [DATA_WIDTH-1:0] fpga_rd_data,
  output logic                  fpga_rd_valid
);

  sdram_req_t             req_q;
  addr_fields_t           fields;
  logic                   in_read_q;
  logic                   read_entry;
  logic [CAS_LATENCY-1:0] rd_pipe;

  // Request held for the whole access
  always_ff @(posedge fpga_clk) begin
    if (start) begin
      req_q <= fpga_request;
    end
  end

  // Host address split into bank, row and column
  assign fields = addr_fields_t'(req_q.addr);

  // Address and bank pins follow the state, commands are aligned by the FSM
  always_comb begin
    row_col = '0;
    bank    = '0;
    case (state)
      ST_INIT: begin
        // Precharge all banks
        row_col[AUTO_PRECHARGE_BIT] = 1'b1;
      end
      ST_MODE: begin
        row_col = MODE_WORD;
      end
      ST_ACTIVATE: begin
        row_col = fields.row;
        bank    = fields.bank;
      end
      ST_READ, ST_WRITE: begin
        row_col                     = ROW_WIDTH'(fields.col);
        row_col[AUTO_PRECHARGE_BIT] = 1'b1;
        bank                        = fields.bank;
      end
      default: begin
        row_col = '0;
      end
    endcase
  end

  // Write word stays on the bus, the pad only drives it while enabled
  assign ram_dq_out = req_q.wr_data;

  always_ff @(posedge fpga_clk or posedge fpga_reset) begin
    if (fpga_reset) begin
      ram_dq_oe <= 1'b0;
    end else begin
      ram_dq_oe <= write_window;
    end
  end

  // First cycle of a read state, back-to-back reads pass through activate
  assign read_entry = (state == ST_READ) && !in_read_q;

  // Valid token walks CAS_LATENCY stages behind the read command
  always_ff @(posedge fpga_clk or posedge fpga_reset) begin
    if (fpga_reset) begin
      in_read_q     <= 1'b0;
      rd_pipe       <= '0;
      fpga_rd_valid <= 1'b0;
    end else begin
      in_read_q     <= (state == ST_READ);
      rd_pipe       <= (rd_pipe << 1) | CAS_LATENCY'(read_entry);
      fpga_rd_valid <= rd_pipe[CAS_LATENCY-1];
    end
  end

  // Captured word held until the next read returns
  always_ff @(posedge fpga_clk) begin
    if (rd_pipe[CAS_LATENCY-1]) begin
      fpga_rd_data <= ram_dq_in;
    end
  end

endmodule

`default_nettype wire

// File: source/sdram_pkg.sv
/* Shared types for the single-rank SDRAM controller with 32-bit data.
   Bursts are fixed at one word and CAS latency at two cycles. */
`default_nettype none

package sdram_pkg;

  // Data and address geometry
  localparam int DATA_WIDTH      = 32;
  localparam int BANK_WIDTH      = 2;
  localparam int ROW_WIDTH       = 12;
  localparam int COL_WIDTH       = 9;
  localparam int HOST_ADDR_WIDTH = BANK_WIDTH + ROW_WIDTH + COL_WIDTH;

  // Read latency in clock cycles, also written into the mode word
  localparam int CAS_LATENCY = 2;

  // A10 selects auto precharge on read/write and all banks on precharge
  localparam int AUTO_PRECHARGE_BIT = 10;

  // Mode register fields
  localparam logic       WRITE_BURST_SINGLE = 1'b1;
  localparam logic       BURST_SEQUENTIAL   = 1'b0;
  localparam logic [2:0] BURST_LENGTH_ONE   = 3'b000;

  // M11..M10 reserved, M9 write burst, M8..M7 op mode, M6..M4 CL, M3 type, M2..M0 length
  localparam logic [ROW_WIDTH-1:0] MODE_WORD = {2'b00, WRITE_BURST_SINGLE, 2'b00,
                                                3'(CAS_LATENCY), BURST_SEQUENTIAL,
                                                BURST_LENGTH_ONE};

  // Command encoding as {cs_n, ras_n, cas_n, we_n}
  typedef enum logic [3:0] {
    CMD_DESELECT  = 4'b1111,
    CMD_NOP       = 4'b0111,
    CMD_READ      = 4'b0101,
    CMD_WRITE     = 4'b0100,
    CMD_ACTIVE    = 4'b0011,
    CMD_PRECHARGE = 4'b0010,
    CMD_REFRESH   = 4'b0001,
    CMD_LOAD_MODE = 4'b0000
  } sdram_cmd_e;

  // Controller states
  typedef enum logic [2:0] {
    ST_INIT,
    ST_MODE,
    ST_IDLE,
    ST_REFRESH,
    ST_ACTIVATE,
    ST_READ,
    ST_WRITE
  } sdram_state_e;

  // Host request, held stable until acknowledged
  typedef struct packed {
    logic [HOST_ADDR_WIDTH-1:0] addr;
    logic [DATA_WIDTH-1:0]      wr_data;
    logic                       wr_en;
    logic                       rd_en;
  } sdram_req_t;

  // Command side of the SDRAM pins
  typedef struct packed {
    sdram_cmd_e             cmd;
    logic [ROW_WIDTH-1:0]   addr;
    logic [BANK_WIDTH-1:0]  bank;
    logic                   clk_en;
  } sdram_pins_t;

  // Host address layout {bank, row, column}
  typedef struct packed {
    logic [BANK_WIDTH-1:0] bank;
    logic [ROW_WIDTH-1:0]  row;
    logic [COL_WIDTH-1:0]  col;
  } addr_fields_t;

endpackage

`default_nettype wire

// File: source/sdram_refresh_timer.sv
/* Counts cycles since the last refresh start. The count saturates at the
   interval, so refresh_due stays high until the FSM begins a refresh. */
`timescale 1ns/10ps
`default_nettype none

module sdram_refresh_timer #(
  parameter int unsigned REFRESH_INTERVAL_CYCLES = 1280
) (
  input  wire  fpga_clk,
  input  wire  fpga_reset,
  input  wire  refresh_start,
  output logic refresh_due
);

  localparam int unsigned CNT_W = $clog2(REFRESH_INTERVAL_CYCLES + 1);
  localparam logic [CNT_W-1:0] INTERVAL_LAST = CNT_W'(REFRESH_INTERVAL_CYCLES);

  // Cycles elapsed since the last refresh command
  logic [CNT_W-1:0] refresh_cnt;

  always_ff @(posedge fpga_clk or posedge fpga_reset) begin
    if (fpga_reset) begin
      refresh_cnt <= '0;
    end else if (refresh_start) begin
      refresh_cnt <= '0;
    end else if (!refresh_due) begin
      // Hold at the interval, no wrap while a refresh is pending
      refresh_cnt <= refresh_cnt + 1'b1;
    end
  end

  // Independent of traffic, the FSM decides when it can act on it
  assign refresh_due = (refresh_cnt >= INTERVAL_LAST);

endmodule

`default_nettype wire

// File: verif/sdram_checker.sv
/* Watches the host port and the SDRAM pins and counts mismatches.
   Reads are only checked for addresses written earlier in the run. */
`timescale 1ns/10ps
`default_nettype none

module sdram_checker
  import sdram_pkg::*;
#(
  parameter int REFRESH_INTERVAL_CYCLES = 150,
  parameter int ACTIVE_WAIT_CYCLES      = 3,
  parameter int WRITE_WAIT_CYCLES       = 6
) (
  input  wire                  fpga_clk,
  input  wire                  fpga_reset,
  input  wire                  fpga_req,
  input  wire sdram_req_t      fpga_request,
  input  wire                  fpga_ack,
  input  wire [DATA_WIDTH-1:0] fpga_rd_data,
  input  wire                  fpga_rd_valid,
  input  wire sdram_pins_t     ram_pins,
  output int                   error_count,
  output int                   ack_count,
  output int                   refresh_count,
  output int                   pending_reads
);

  localparam int GAP_MAX = REFRESH_INTERVAL_CYCLES + ACTIVE_WAIT_CYCLES + WRITE_WAIT_CYCLES;

  // Expected contents by host address, filled at write ack
  logic [DATA_WIDTH-1:0] shadow [logic [HOST_ADDR_WIDTH-1:0]];
  logic [DATA_WIDTH-1:0] exp_q [$];
  int                    due_q [$];
  sdram_cmd_e            boot_cmds [4];
  addr_fields_t          f;
  logic [ROW_WIDTH-1:0]  col_pins;
  int                    cycle;
  int                    last_refresh;
  int                    boot_step;

  initial begin
    boot_cmds     = '{CMD_PRECHARGE, CMD_REFRESH, CMD_REFRESH, CMD_LOAD_MODE};
    error_count   = 0;
    ack_count     = 0;
    refresh_count = 0;
    pending_reads = 0;
    cycle         = 0;
    last_refresh  = 0;
    boot_step     = 0;
  end

  always @(posedge fpga_clk) begin
    if (!fpga_reset) begin
      f        = addr_fields_t'(fpga_request.addr);
      col_pins = ROW_WIDTH'(f.col) | (ROW_WIDTH'(1) << AUTO_PRECHARGE_BIT);
      // Clock enable low on the first cycle only
      if (ram_pins.clk_en != (cycle != 0)) begin
        $display("Error at %0t ns: clk_en expected %b got %b", $time, cycle != 0,
                 ram_pins.clk_en);
        error_count++;
      end
      // Power-up order, idle commands in between are skipped
      if (boot_step < 4 && ram_pins.cmd != CMD_NOP && ram_pins.cmd != CMD_DESELECT) begin
        if (ram_pins.cmd != boot_cmds[boot_step]) begin
          $display("Error at %0t ns: ram_pins.cmd expected %s got %s", $time,
                   boot_cmds[boot_step].name(), ram_pins.cmd.name());
          error_count++;
        end else if (ram_pins.cmd == CMD_PRECHARGE && !ram_pins.addr[AUTO_PRECHARGE_BIT]) begin
          $display("Error at %0t ns: ram_pins.addr expected A10 high got %h", $time,
                   ram_pins.addr);
          error_count++;
        end else if (ram_pins.cmd == CMD_LOAD_MODE && ram_pins.addr != MODE_WORD) begin
          $display("Error at %0t ns: ram_pins.addr expected %h got %h", $time, MODE_WORD,
                   ram_pins.addr);
          error_count++;
        end
        if (ram_pins.cmd == CMD_LOAD_MODE) begin
          last_refresh = cycle;
        end
        boot_step++;
      end else if (boot_step >= 4) begin
        // Periodic refresh
        if (ram_pins.cmd == CMD_REFRESH) begin
          refresh_count++;
          last_refresh = cycle;
        end else if (cycle - last_refresh == GAP_MAX + 1) begin
          $display("No refresh command within %0d cycles at %0t ns", GAP_MAX, $time);
          error_count++;
        end
        // Row on activate, column with auto precharge on the access
        if (ram_pins.cmd == CMD_ACTIVE &&
            (ram_pins.bank != f.bank || ram_pins.addr != f.row)) begin
          $display("Error at %0t ns: ram_pins bank/row expected %h/%h got %h/%h", $time,
                   f.bank, f.row, ram_pins.bank, ram_pins.addr);
          error_count++;
        end
        if ((ram_pins.cmd == CMD_READ || ram_pins.cmd == CMD_WRITE) &&
            (ram_pins.bank != f.bank || ram_pins.addr != col_pins)) begin
          $display("Error at %0t ns: ram_pins bank/col expected %h/%h got %h/%h", $time,
                   f.bank, col_pins, ram_pins.bank, ram_pins.addr);
          error_count++;
        end
      end
      if (fpga_ack) begin
        ack_count++;
        if (!fpga_req) begin
          $display("Acknowledge without a pending request at %0t ns", $time);
          error_count++;
        end
        if (fpga_request.wr_en) begin
          shadow[fpga_request.addr] = fpga_request.wr_data;
        end else if (!shadow.exists(fpga_request.addr)) begin
          $display("Read of an address never written at %0t ns", $time);
          error_count++;
        end else begin
          exp_q.push_back(shadow[fpga_request.addr]);
          due_q.push_back(cycle + CAS_LATENCY + 1);
        end
      end
      if (fpga_rd_valid) begin
        if (exp_q.size() == 0) begin
          $display("Read data valid with no read outstanding at %0t ns", $time);
          error_count++;
        end else begin
          if (due_q[0] != cycle) begin
            $display("Error at %0t ns: fpga_rd_valid cycle expected %0d got %0d", $time,
                     due_q[0], cycle);
            error_count++;
          end
          if (fpga_rd_data != exp_q[0]) begin
            $display("Error at %0t ns: fpga_rd_data expected %h got %h", $time, exp_q[0],
                     fpga_rd_data);
            error_count++;
          end
          void'(exp_q.pop_front());
          void'(due_q.pop_front());
        end
      end
      pending_reads = exp_q.size();
      cycle++;
    end
  end

endmodule

`default_nettype wire

// File: verif/sdram_model.sv
/* Behavioral SDRAM for simulation. Rows are tracked per bank, bursts are
   one word, and never-written words return a pattern of their address. */
`timescale 1ns/10ps
`default_nettype none

module sdram_model
  import sdram_pkg::*;
(
  input  wire                   fpga_clk,
  input  wire                   fpga_reset,
  input  wire sdram_pins_t      ram_pins,
  input  wire  [DATA_WIDTH-1:0] ram_dq_out,
  input  wire                   ram_dq_oe,
  output logic [DATA_WIDTH-1:0] ram_dq_in
);

  logic [DATA_WIDTH-1:0]      mem [logic [HOST_ADDR_WIDTH-1:0]];
  logic [ROW_WIDTH-1:0]       open_row [4];
  logic [DATA_WIDTH-1:0]      rd_pipe [CAS_LATENCY];
  logic [HOST_ADDR_WIDTH-1:0] key;

  // Word location from the open row of the addressed bank
  assign key = {ram_pins.bank, open_row[ram_pins.bank], ram_pins.addr[COL_WIDTH-1:0]};

  // Read word appears CAS_LATENCY cycles after the read command
  assign ram_dq_in = rd_pipe[CAS_LATENCY-1];

  always @(posedge fpga_clk or posedge fpga_reset) begin
    if (fpga_reset) begin
      for (int i = 0; i < 4; i++) begin
        open_row[i] <= '0;
      end
      for (int i = 0; i < CAS_LATENCY; i++) begin
        rd_pipe[i] <= '0;
      end
    end else begin
      for (int i = CAS_LATENCY - 1; i > 0; i--) begin
        rd_pipe[i] <= rd_pipe[i-1];
      end
      rd_pipe[0] <= '0;
      if (ram_pins.cmd == CMD_ACTIVE) begin
        open_row[ram_pins.bank] <= ram_pins.addr;
      end
      // Data only counts when the controller drives the bus
      if (ram_pins.cmd == CMD_WRITE && ram_dq_oe) begin
        mem[key] = ram_dq_out;
      end
      if (ram_pins.cmd == CMD_READ) begin
        rd_pipe[0] <= mem.exists(key) ? mem[key] : ({9'h0, key} ^ 32'ha5a5_a5a5);
      end
    end
  end

endmodule

`default_nettype wire

// File: verif/sdram_sva.sv
/* Command legality on the controller pins, bound into the top level */
`timescale 1ns/10ps
`default_nettype none

module sdram_sva
  import sdram_pkg::*;
(
  input wire              fpga_clk,
  input wire              fpga_reset,
  input wire              fpga_ack,
  input wire              ram_dq_oe,
  input wire sdram_pins_t ram_pins
);

  logic mode_loaded;

  always_ff @(posedge fpga_clk or posedge fpga_reset) begin
    if (fpga_reset) begin
      mode_loaded <= 1'b0;
    end else if (ram_pins.cmd == CMD_LOAD_MODE) begin
      mode_loaded <= 1'b1;
    end
  end

  ack_on_access: assert property (@(posedge fpga_clk) disable iff (fpga_reset)
    fpga_ack |-> (ram_pins.cmd == CMD_READ || ram_pins.cmd == CMD_WRITE))
    else $error("fpga_ack without a read or write command");

  // Bus driven only in the write command cycle
  oe_with_write: assert property (@(posedge fpga_clk) disable iff (fpga_reset)
    ram_dq_oe |-> (ram_pins.cmd == CMD_WRITE))
    else $error("ram_dq_oe high without a write command");

  no_access_before_mode: assert property (@(posedge fpga_clk) disable iff (fpga_reset)
    !mode_loaded |-> !(ram_pins.cmd inside {CMD_ACTIVE, CMD_READ, CMD_WRITE}))
    else $error("access command before load_mode");

endmodule

`default_nettype wire

// File: verif/tb_sdram_controller.sv
/* Testbench for the SDRAM controller with shortened waits. Every read in
   the table targets an address written earlier. */
`timescale 1ns/10ps
`default_nettype none

module tb_sdram_controller;
  import sdram_pkg::*;

  localparam int INIT_WAIT     = 20;
  localparam int REFRESH_EVERY = 150;
  localparam int ACTIVE_WAIT   = 3;
  localparam int WRITE_WAIT    = 6;
  localparam int ACK_TIMEOUT   = 200;
  localparam int OP_WRITE      = 0;
  localparam int OP_READ       = 1;
  localparam int OP_IDLE       = 2;
  localparam int NUM_OPS       = 15;

  // Operation, host address, idle cycles
  localparam int OP_TBL [NUM_OPS] = '{0, 0, 1, 1, 0, 1, 0, 1, 2, 1, 1, 0, 1, 1, 1};
  localparam logic [HOST_ADDR_WIDTH-1:0] ADDR_TBL [NUM_OPS] = '{
    23'h000005, 23'h2abc13, 23'h000005, 23'h2abc13, 23'h7fffff, 23'h7fffff,
    23'h000005, 23'h000005, 23'h000000, 23'h2abc13, 23'h7fffff, 23'h41f0a0,
    23'h41f0a0, 23'h000005, 23'h2abc13};
  localparam int IDLE_TBL [NUM_OPS] = '{0, 0, 0, 0, 0, 0, 0, 0, 200, 0, 0, 0, 0, 0, 0};

  logic                  fpga_clk = 1'b0;
  logic                  fpga_reset;
  logic                  fpga_req;
  sdram_req_t            fpga_request;
  logic                  fpga_ack;
  logic [DATA_WIDTH-1:0] fpga_rd_data;
  logic                  fpga_rd_valid;
  sdram_pins_t           ram_pins;
  logic [DATA_WIDTH-1:0] ram_dq_out;
  logic                  ram_dq_oe;
  logic [DATA_WIDTH-1:0] ram_dq_in;
  logic [31:0]           lfsr;
  int                    error_count;
  int                    ack_count;
  int                    refresh_count;
  int                    pending_reads;
  int                    requests;
  int                    timeouts;

  always #20 fpga_clk = ~fpga_clk;

  sdram_controller #(
    .INIT_WAIT_CYCLES        (INIT_WAIT),
    .ACTIVE_WAIT_CYCLES      (ACTIVE_WAIT),
    .WRITE_WAIT_CYCLES       (WRITE_WAIT),
    .REFRESH_INTERVAL_CYCLES (REFRESH_EVERY)
  ) sdram_controller_inst (
    .fpga_clk, .fpga_reset, .fpga_req, .fpga_request, .fpga_ack, .fpga_rd_data,
    .fpga_rd_valid, .ram_pins, .ram_dq_out, .ram_dq_oe, .ram_dq_in
  );

  sdram_model model_inst (.fpga_clk, .fpga_reset, .ram_pins, .ram_dq_out, .ram_dq_oe,
                          .ram_dq_in);

  sdram_checker #(
    .REFRESH_INTERVAL_CYCLES (REFRESH_EVERY),
    .ACTIVE_WAIT_CYCLES      (ACTIVE_WAIT),
    .WRITE_WAIT_CYCLES       (WRITE_WAIT)
  ) checker_inst (
    .fpga_clk, .fpga_reset, .fpga_req, .fpga_request, .fpga_ack, .fpga_rd_data,
    .fpga_rd_valid, .ram_pins, .error_count, .ack_count, .refresh_count, .pending_reads
  );

  bind sdram_controller sdram_sva sva_inst (.fpga_clk, .fpga_reset, .fpga_ack, .ram_dq_oe,
                                            .ram_pins);

  // Galois LFSR, one step per random bit
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'hb4bc_d35c) : (s >> 1);
  endfunction

  task automatic random_word(output logic [DATA_WIDTH-1:0] word);
    for (int b = 0; b < DATA_WIDTH; b++) begin
      word = {word[DATA_WIDTH-2:0], lfsr[0]};
      lfsr = lfsr_next(lfsr);
    end
  endtask

  task automatic report_and_finish();
    int errors;
    errors = error_count;
    if (ack_count != requests) begin
      $display("Acknowledge count %0d differs from request count %0d", ack_count, requests);
      errors++;
    end
    if (refresh_count == 0) begin
      $display("No periodic refresh was seen");
      errors++;
    end
    $display("Errors: %0d, timeouts: %0d, requests: %0d, refreshes: %0d",
             errors, timeouts, requests, refresh_count);
    if (errors == 0 && timeouts == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  endtask

  // Ack is sampled at the edge, then inputs move 2 ns later
  task automatic wait_for_ack();
    int n;
    n = 0;
    do begin
      @(posedge fpga_clk);
      n++;
    end while (!fpga_ack && n < ACK_TIMEOUT);
    #2;
    if (n >= ACK_TIMEOUT) begin
      $display("No acknowledge within %0d cycles at %0t ns", ACK_TIMEOUT, $time);
      timeouts++;
    end
  endtask

  task automatic wait_for_reads();
    int n;
    n = 0;
    while (pending_reads != 0 && n < ACK_TIMEOUT) begin
      @(posedge fpga_clk);
      n++;
    end
    if (n >= ACK_TIMEOUT) begin
      $display("Read data never returned for %0d reads", pending_reads);
      timeouts++;
    end
  endtask

  initial begin
    logic [DATA_WIDTH-1:0] data;
    fpga_reset   = 1'b1;
    fpga_req     = 1'b0;
    fpga_request = '0;
    lfsr         = 32'h4427a54a;
    requests     = 0;
    timeouts     = 0;
    repeat (3) @(posedge fpga_clk);
    #2 fpga_reset = 1'b0;
    // Stop issuing requests once one has gone unanswered
    for (int i = 0; i < NUM_OPS && timeouts == 0; i++) begin
      if (OP_TBL[i] == OP_IDLE) begin
        fpga_req = 1'b0;
        repeat (IDLE_TBL[i]) @(posedge fpga_clk);
        #2;
      end else begin
        data = '0;
        if (OP_TBL[i] == OP_WRITE) begin
          random_word(data);
        end
        fpga_request.addr    = ADDR_TBL[i];
        fpga_request.wr_data = data;
        fpga_request.wr_en   = (OP_TBL[i] == OP_WRITE);
        fpga_request.rd_en   = (OP_TBL[i] == OP_READ);
        fpga_req             = 1'b1;
        requests++;
        wait_for_ack();
      end
    end
    fpga_req = 1'b0;
    if (timeouts == 0) begin
      wait_for_reads();
    end
    report_and_finish();
  end

endmodule

`default_nettype wire
